// ==== rtl/sb_consts.svh ====
`ifndef SB_CONSTS_SVH
`define SB_CONSTS_SVH

// physical address width, wide enough for the 12 bit page offset plus index bits
`define SB_PLEN 16

// data path width, byte enables are a eighth of it
`define SB_XLEN 64

// depth of the speculative queue, stores wait here until commit or flush
`define SB_DEPTH_SPEC 4

// depth of the commit queue, committed stores wait here for a memory grant
`define SB_DEPTH_COMMIT 4

// number of data words in the memory
`define SB_MEM_WORDS 256

`endif

// ==== rtl/lsu_op_pkg.sv ====
package lsu_op_pkg;

    // ----------------------------------------------------------------------
    // core side encodings
    // ----------------------------------------------------------------------

    // store opcodes as issued by the core, one per access width
    typedef enum logic [1:0] {
        SB = 2'd0,
        SH = 2'd1,
        SW = 2'd2,
        SD = 2'd3
    } lsu_op_e;

    // access size in log2 bytes, so a size value n covers 2**n bytes
    typedef enum logic [1:0] {
        BYTE  = 2'd0,
        HALF  = 2'd1,
        WORD  = 2'd2,
        DWORD = 2'd3
    } acc_size_e;

endpackage

// ==== rtl/mem_port_pkg.sv ====
`include "sb_consts.svh"

package mem_port_pkg;

    // ----------------------------------------------------------------------
    // memory side types
    // ----------------------------------------------------------------------

    // width of a word index into the data memory
    localparam int unsigned WORD_ADDR_W = $clog2(`SB_MEM_WORDS);

    // word index, taken from the address bits just above the byte offset
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;

    // one store as held in either queue of the store buffer
    typedef struct packed {
        logic [`SB_PLEN-1:0]     paddr;
        logic [`SB_XLEN-1:0]     data;
        logic [`SB_XLEN/8-1:0]   be;
        lsu_op_pkg::acc_size_e   size;
        // the entry holds a live store, used by the page offset check
        logic                    valid;
    } sb_entry_t;

endpackage

// ==== rtl/store_req_if.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

// one decoded store on its way from decode into the store buffer
interface store_req_if import lsu_op_pkg::*; ();

    // single cycle push strobe, never raised for a misaligned store
    logic                    valid;
    // physical address of the store
    logic [`SB_PLEN-1:0]     paddr;
    // store data already moved into its byte lanes
    logic [`SB_XLEN-1:0]     data;
    // byte enables matching the lanes of data
    logic [`SB_XLEN/8-1:0]   be;
    // access size of the store
    acc_size_e               size;

    // the decode stage produces the store
    modport decode (
        output valid, paddr, data, be, size
    );

    // the store buffer consumes it
    modport buffer (
        input  valid, paddr, data, be, size
    );

endinterface

// ==== rtl/store_decode.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module store_decode import lsu_op_pkg::*; (
    input  logic                 st_valid_i,
    input  lsu_op_e              st_op_i,
    input  logic [`SB_PLEN-1:0]  st_addr_i,
    input  logic [`SB_XLEN-1:0]  st_data_i,
    output logic                 misaligned_o,
    store_req_if.decode          req
);

    localparam int unsigned BE_W = `SB_XLEN / 8;

    // unshifted byte mask for the access size
    logic [BE_W-1:0] be_base;
    // address bits that must be zero for the access size
    logic            unaligned;

    // ----------------------------------------------------------------------
    // size and alignment
    // ----------------------------------------------------------------------

    // each opcode maps to one access size and a mask of that many low bytes
    always_comb begin : p_size
        req.size  = BYTE;
        be_base   = 8'h01;
        unaligned = 1'b0;
        case (st_op_i)
            SB: begin
                req.size  = BYTE;
                be_base   = 8'h01;
                unaligned = 1'b0;
            end
            SH: begin
                req.size  = HALF;
                be_base   = 8'h03;
                unaligned = st_addr_i[0];
            end
            SW: begin
                req.size  = WORD;
                be_base   = 8'h0f;
                unaligned = |st_addr_i[1:0];
            end
            SD: begin
                req.size  = DWORD;
                be_base   = 8'hff;
                unaligned = |st_addr_i[2:0];
            end
            default: begin
                req.size  = BYTE;
                be_base   = 8'h01;
                unaligned = 1'b0;
            end
        endcase
    end

    // a misaligned store is reported in the same cycle and never pushed
    assign misaligned_o = st_valid_i & unaligned;
    assign req.valid    = st_valid_i & ~unaligned;
    assign req.paddr    = st_addr_i;

    // the byte offset inside the word selects the lanes
    assign req.be   = be_base << st_addr_i[2:0];
    assign req.data = st_data_i << {st_addr_i[2:0], 3'b000};

    // an aligned push keeps all of its bytes inside the word
    always_comb begin : p_be_check
        assert #0 (!req.valid || ($countones(req.be) == (1 << req.size)))
            else $error("store_decode: byte enables %h do not fit size %s",
                        req.be, req.size.name());
    end

endmodule

// ==== rtl/store_buffer.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module store_buffer import mem_port_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   flush_i,
    store_req_if.buffer            req,
    input  logic                   commit_i,
    output logic                   commit_ready_o,
    output logic                   ready_o,
    input  logic                   ld_valid_i,
    input  logic [`SB_PLEN-1:0]    ld_addr_i,
    output logic                   page_offset_matches_o,
    output logic                   mem_req_o,
    input  logic                   mem_gnt_i,
    output word_addr_t             mem_waddr_o,
    output logic [`SB_XLEN-1:0]    mem_wdata_o,
    output logic [`SB_XLEN/8-1:0]  mem_wbe_o,
    output logic                   no_st_pending_o,
    output logic                   empty_o
);

    localparam int unsigned SPEC_PTR_W   = $clog2(`SB_DEPTH_SPEC);
    localparam int unsigned COMMIT_PTR_W = $clog2(`SB_DEPTH_COMMIT);

    // stores that may still be flushed
    sb_entry_t spec_q_q [`SB_DEPTH_SPEC-1:0];
    sb_entry_t spec_q_n [`SB_DEPTH_SPEC-1:0];
    // stores that will reach memory no matter what
    sb_entry_t commit_q_q [`SB_DEPTH_COMMIT-1:0];
    sb_entry_t commit_q_n [`SB_DEPTH_COMMIT-1:0];

    logic [SPEC_PTR_W-1:0]   spec_rd_q, spec_rd_n;
    logic [SPEC_PTR_W-1:0]   spec_wr_q, spec_wr_n;
    logic [SPEC_PTR_W:0]     spec_cnt_q, spec_cnt_n;
    logic [COMMIT_PTR_W-1:0] commit_rd_q, commit_rd_n;
    logic [COMMIT_PTR_W-1:0] commit_wr_q, commit_wr_n;
    logic [COMMIT_PTR_W:0]   commit_cnt_q, commit_cnt_n;

    // ----------------------------------------------------------------------
    // speculative queue, fed by decode
    // ----------------------------------------------------------------------

    // one slot is held back so that a push in the cycle of a full count
    // still fits while a commit frees the head
    assign ready_o = (spec_cnt_q < (`SB_DEPTH_SPEC - 1)) || commit_i;

    always_comb begin : p_spec_next
        spec_q_n   = spec_q_q;
        spec_rd_n  = spec_rd_q;
        spec_wr_n  = spec_wr_q;
        spec_cnt_n = spec_cnt_q;

        // a push lands at the write pointer as a valid entry
        if (req.valid) begin
            spec_q_n[spec_wr_q].paddr = req.paddr;
            spec_q_n[spec_wr_q].data  = req.data;
            spec_q_n[spec_wr_q].be    = req.be;
            spec_q_n[spec_wr_q].size  = req.size;
            spec_q_n[spec_wr_q].valid = 1'b1;
            spec_wr_n  = spec_wr_q + 1'b1;
            spec_cnt_n = spec_cnt_n + 1'b1;
        end

        // commit hands the oldest entry to the commit queue
        if (commit_i) begin
            spec_q_n[spec_rd_q].valid = 1'b0;
            spec_rd_n  = spec_rd_q + 1'b1;
            spec_cnt_n = spec_cnt_n - 1'b1;
        end

        // flush drops every speculative store, a push in this cycle included
        if (flush_i) begin
            for (int unsigned i = 0; i < `SB_DEPTH_SPEC; i++) begin
                spec_q_n[i].valid = 1'b0;
            end
            spec_wr_n  = spec_rd_q;
            spec_cnt_n = '0;
        end
    end

    // ----------------------------------------------------------------------
    // commit queue, drained into memory
    // ----------------------------------------------------------------------

    assign commit_ready_o  = (commit_cnt_q < `SB_DEPTH_COMMIT);
    assign no_st_pending_o = (commit_cnt_q == '0);
    assign empty_o         = (spec_cnt_q == '0) && no_st_pending_o;

    // the head entry is presented to memory for as long as it is valid
    assign mem_req_o   = commit_q_q[commit_rd_q].valid;
    assign mem_waddr_o = commit_q_q[commit_rd_q].paddr[WORD_ADDR_W+2:3];
    assign mem_wdata_o = commit_q_q[commit_rd_q].data;
    assign mem_wbe_o   = commit_q_q[commit_rd_q].be;

    always_comb begin : p_commit_next
        commit_q_n   = commit_q_q;
        commit_rd_n  = commit_rd_q;
        commit_wr_n  = commit_wr_q;
        commit_cnt_n = commit_cnt_q;

        // a granted write retires the head
        if (mem_req_o && mem_gnt_i) begin
            commit_q_n[commit_rd_q].valid = 1'b0;
            commit_rd_n  = commit_rd_q + 1'b1;
            commit_cnt_n = commit_cnt_n - 1'b1;
        end

        // the speculative head moves over with its valid flag still set
        if (commit_i) begin
            commit_q_n[commit_wr_q] = spec_q_q[spec_rd_q];
            commit_wr_n  = commit_wr_q + 1'b1;
            commit_cnt_n = commit_cnt_n + 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // page offset checker
    // ----------------------------------------------------------------------

    // bits 11:3 pick the double word inside the page, a load that shares
    // them with any pending store has to wait for the drain
    always_comb begin : p_offset_check
        page_offset_matches_o = 1'b0;
        for (int unsigned i = 0; i < `SB_DEPTH_COMMIT; i++) begin
            if (commit_q_q[i].valid && (commit_q_q[i].paddr[11:3] == ld_addr_i[11:3])) begin
                page_offset_matches_o = ld_valid_i;
            end
        end
        for (int unsigned i = 0; i < `SB_DEPTH_SPEC; i++) begin
            if (spec_q_q[i].valid && (spec_q_q[i].paddr[11:3] == ld_addr_i[11:3])) begin
                page_offset_matches_o = ld_valid_i;
            end
        end
        // the store entering the queue in this cycle counts as well
        if (req.valid && (req.paddr[11:3] == ld_addr_i[11:3])) begin
            page_offset_matches_o = ld_valid_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_spec_regs
        if (!rst_ni) begin
            spec_q_q   <= '{default: '0};
            spec_rd_q  <= '0;
            spec_wr_q  <= '0;
            spec_cnt_q <= '0;
        end else begin
            spec_q_q   <= spec_q_n;
            spec_rd_q  <= spec_rd_n;
            spec_wr_q  <= spec_wr_n;
            spec_cnt_q <= spec_cnt_n;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_commit_regs
        if (!rst_ni) begin
            commit_q_q   <= '{default: '0};
            commit_rd_q  <= '0;
            commit_wr_q  <= '0;
            commit_cnt_q <= '0;
        end else begin
            commit_q_q   <= commit_q_n;
            commit_rd_q  <= commit_rd_n;
            commit_wr_q  <= commit_wr_n;
            commit_cnt_q <= commit_cnt_n;
        end
    end

    // ----------------------------------------------------------------------
    // assertions
    // ----------------------------------------------------------------------

    // commit and flush are decided in the same core stage and exclude each other
    a_commit_flush: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |-> !commit_i)
        else $error("store_buffer: commit and flush in the same cycle");

    a_spec_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (spec_cnt_q == `SB_DEPTH_SPEC) |-> !req.valid)
        else $error("store_buffer: push into a full speculative queue");

    a_spec_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (spec_cnt_q == '0) |-> !commit_i)
        else $error("store_buffer: commit with no speculative store");

    a_commit_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (commit_cnt_q == `SB_DEPTH_COMMIT) |-> !commit_i)
        else $error("store_buffer: commit into a full commit queue");

endmodule

// ==== rtl/data_mem.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module data_mem import mem_port_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_ni,
    input  logic                   ld_valid_i,
    input  logic                   ld_stall_i,
    input  logic [`SB_PLEN-1:0]    ld_addr_i,
    output logic                   ld_rvalid_o,
    output logic [`SB_XLEN-1:0]    ld_rdata_o,
    input  logic                   wr_req_i,
    output logic                   wr_gnt_o,
    input  word_addr_t             wr_addr_i,
    input  logic [`SB_XLEN-1:0]    wr_data_i,
    input  logic [`SB_XLEN/8-1:0]  wr_be_i
);

    localparam int unsigned BE_W = `SB_XLEN / 8;

    logic [`SB_XLEN-1:0] mem_q [`SB_MEM_WORDS];
    word_addr_t          ld_word;
    // a load that is actually served this cycle
    logic                ld_serve;

    assign ld_word  = ld_addr_i[WORD_ADDR_W+2:3];
    assign ld_serve = ld_valid_i & ~ld_stall_i;

    // loads win the single port, the store simply waits in its queue
    assign wr_gnt_o = wr_req_i & ~ld_serve;

    // ----------------------------------------------------------------------
    // array and byte merge
    // ----------------------------------------------------------------------

    always_ff @(posedge clk_i or negedge rst_ni) begin : p_array
        if (!rst_ni) begin
            for (int unsigned w = 0; w < `SB_MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (wr_gnt_o) begin
            // only the enabled bytes change, the rest of the word is kept
            for (int unsigned b = 0; b < BE_W; b++) begin
                if (wr_be_i[b]) begin
                    mem_q[wr_addr_i][8*b +: 8] <= wr_data_i[8*b +: 8];
                end
            end
        end
    end

    // read data shows up one cycle after the load is served
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_rvalid
        if (!rst_ni) begin
            ld_rvalid_o <= 1'b0;
        end else begin
            ld_rvalid_o <= ld_serve;
        end
    end

    always_ff @(posedge clk_i) begin : p_rdata
        if (ld_serve) begin
            ld_rdata_o <= mem_q[ld_word];
        end
    end

    // a request that a load blocked stays up with the same head entry
    a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (wr_req_i && !wr_gnt_o) |=> (wr_req_i && $stable(wr_addr_i) && $stable(wr_be_i)))
        else $error("data_mem: write request dropped or changed before its grant");

endmodule

// ==== rtl/store_path_top.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module store_path_top import lsu_op_pkg::*, mem_port_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    // store side
    input  logic                 st_valid_i,
    input  lsu_op_e              st_op_i,
    input  logic [`SB_PLEN-1:0]  st_addr_i,
    input  logic [`SB_XLEN-1:0]  st_data_i,
    output logic                 st_ready_o,
    output logic                 st_misaligned_o,
    // commit control
    input  logic                 commit_i,
    output logic                 commit_ready_o,
    input  logic                 flush_i,
    // load side
    input  logic                 ld_valid_i,
    input  logic [`SB_PLEN-1:0]  ld_addr_i,
    output logic                 ld_stall_o,
    output logic                 ld_rvalid_o,
    output logic [`SB_XLEN-1:0]  ld_rdata_o,
    // status
    output logic                 no_st_pending_o,
    output logic                 sb_empty_o
);

    // decoded store from decode into the buffer
    store_req_if st_req ();

    logic                   page_match;
    logic                   mem_req;
    logic                   mem_gnt;
    word_addr_t             mem_waddr;
    logic [`SB_XLEN-1:0]    mem_wdata;
    logic [`SB_XLEN/8-1:0]  mem_wbe;

    // the stall seen by the core is also what holds the load off the memory
    assign ld_stall_o = ld_valid_i & page_match;

    store_decode u_decode (
        .st_valid_i   (st_valid_i),
        .st_op_i      (st_op_i),
        .st_addr_i    (st_addr_i),
        .st_data_i    (st_data_i),
        .misaligned_o (st_misaligned_o),
        .req          (st_req.decode)
    );

    store_buffer u_buffer (
        .clk_i (clk_i), .rst_ni (rst_ni), .flush_i (flush_i),
        .req (st_req.buffer),
        .commit_i (commit_i), .commit_ready_o (commit_ready_o), .ready_o (st_ready_o),
        .ld_valid_i (ld_valid_i), .ld_addr_i (ld_addr_i), .page_offset_matches_o (page_match),
        .mem_req_o (mem_req), .mem_gnt_i (mem_gnt), .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata), .mem_wbe_o (mem_wbe),
        .no_st_pending_o (no_st_pending_o), .empty_o (sb_empty_o)
    );

    data_mem u_mem (
        .clk_i (clk_i), .rst_ni (rst_ni),
        .ld_valid_i (ld_valid_i), .ld_stall_i (ld_stall_o), .ld_addr_i (ld_addr_i),
        .ld_rvalid_o (ld_rvalid_o), .ld_rdata_o (ld_rdata_o),
        .wr_req_i (mem_req), .wr_gnt_o (mem_gnt), .wr_addr_i (mem_waddr),
        .wr_data_i (mem_wdata), .wr_be_i (mem_wbe)
    );

endmodule

// ==== testbench/sb_checker.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module sb_checker import lsu_op_pkg::*, mem_port_pkg::*; (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 st_valid_i,
    input  lsu_op_e              st_op_i,
    input  logic [`SB_PLEN-1:0]  st_addr_i,
    input  logic [`SB_XLEN-1:0]  st_data_i,
    input  logic                 st_ready_o,
    input  logic                 st_misaligned_o,
    input  logic                 commit_i,
    input  logic                 commit_ready_o,
    input  logic                 flush_i,
    input  logic                 ld_valid_i,
    input  logic [`SB_PLEN-1:0]  ld_addr_i,
    input  logic                 ld_stall_o,
    input  logic                 ld_rvalid_o,
    input  logic [`SB_XLEN-1:0]  ld_rdata_o,
    input  logic                 no_st_pending_o,
    input  logic                 sb_empty_o,
    output int                   errors_o,
    output int                   checks_o
);

    // shadow state, holds what the memory and both queues should contain
    logic [`SB_XLEN-1:0] shadow_mem [`SB_MEM_WORDS];
    sb_entry_t           spec_q [$];
    sb_entry_t           commit_q [$];
    // a load served at the last edge and the word it must return
    logic                rd_pending;
    logic [`SB_XLEN-1:0] rd_word;
    logic                push, stall, serve;
    sb_entry_t           e;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    // ----------------------------------------------------------------------
    // reference rules
    // ----------------------------------------------------------------------

    function automatic acc_size_e size_of_op(input lsu_op_e op);
        case (op)
            SB:      return BYTE;
            SH:      return HALF;
            SW:      return WORD;
            default: return DWORD;
        endcase
    endfunction

    // a store must start on a multiple of its own width
    function automatic logic misaligned(input lsu_op_e op, input logic [`SB_PLEN-1:0] addr);
        int n;
        n = 1 << size_of_op(op);
        return (addr[2:0] % n) != 0;
    endfunction

    // bytes from the offset up to offset plus width are written
    function automatic logic [`SB_XLEN/8-1:0] lane_mask(input acc_size_e size, input int off);
        logic [`SB_XLEN/8-1:0] m;
        for (int b = 0; b < `SB_XLEN/8; b++) begin
            m[b] = (b >= off) && (b < off + (1 << size));
        end
        return m;
    endfunction

    // byte k of the store data lands in byte offset plus k of the word
    function automatic logic [`SB_XLEN-1:0] merge_store(input logic [`SB_XLEN-1:0] old,
                                                        input sb_entry_t st);
        logic [`SB_XLEN-1:0]   w;
        logic [`SB_XLEN/8-1:0] m;
        int                    off;
        w   = old;
        off = st.paddr[2:0];
        m   = lane_mask(st.size, off);
        for (int b = 0; b < `SB_XLEN/8; b++) begin
            if (m[b]) begin
                w[8*b +: 8] = st.data[8*(b-off) +: 8];
            end
        end
        return w;
    endfunction

    // any pending store in the same double word of the page
    function automatic logic page_hit(input logic [`SB_PLEN-1:0] addr);
        foreach (spec_q[i]) begin
            if (spec_q[i].paddr[11:3] == addr[11:3]) return 1'b1;
        end
        foreach (commit_q[i]) begin
            if (commit_q[i].paddr[11:3] == addr[11:3]) return 1'b1;
        end
        return 1'b0;
    endfunction

    task automatic compare_val(input string name, input logic [`SB_XLEN-1:0] exp,
                               input logic [`SB_XLEN-1:0] act);
        checks_o++;
        if (act !== exp) begin
            errors_o++;
            $display("mismatch %s: expected %h, actual %h at %0t", name, exp, act, $time);
        end
    endtask

    // ----------------------------------------------------------------------
    // compare at the falling edge, then step the model past the next rise
    // ----------------------------------------------------------------------

    always @(negedge clk_i) begin : compare_step
        if (!rst_ni) begin
            spec_q.delete();
            commit_q.delete();
            rd_pending = 1'b0;
            for (int w = 0; w < `SB_MEM_WORDS; w++) begin
                shadow_mem[w] = '0;
            end
        end else begin
            push  = st_valid_i && !misaligned(st_op_i, st_addr_i);
            stall = ld_valid_i && (page_hit(ld_addr_i)
                    || (push && (st_addr_i[11:3] == ld_addr_i[11:3])));
            serve = ld_valid_i && !stall;

            compare_val("st_misaligned_o", st_valid_i && !push, st_misaligned_o);
            compare_val("st_ready_o", (spec_q.size() < `SB_DEPTH_SPEC - 1) || commit_i,
                        st_ready_o);
            compare_val("commit_ready_o", commit_q.size() < `SB_DEPTH_COMMIT, commit_ready_o);
            compare_val("no_st_pending_o", commit_q.size() == 0, no_st_pending_o);
            compare_val("sb_empty_o", (spec_q.size() == 0) && (commit_q.size() == 0),
                        sb_empty_o);
            compare_val("ld_stall_o", stall, ld_stall_o);
            compare_val("ld_rvalid_o", rd_pending, ld_rvalid_o);
            if (rd_pending) begin
                compare_val("ld_rdata_o", rd_word, ld_rdata_o);
            end

            // the load owns the port, so a write only drains without one
            rd_pending = serve;
            if (serve) begin
                rd_word = shadow_mem[ld_addr_i[WORD_ADDR_W+2:3]];
            end else if (commit_q.size() > 0) begin
                e = commit_q.pop_front();
                shadow_mem[e.paddr[WORD_ADDR_W+2:3]] =
                    merge_store(shadow_mem[e.paddr[WORD_ADDR_W+2:3]], e);
            end
            if (commit_i && (spec_q.size() > 0)) begin
                commit_q.push_back(spec_q.pop_front());
            end
            if (push) begin
                e       = '0;
                e.paddr = st_addr_i;
                e.data  = st_data_i;
                e.size  = size_of_op(st_op_i);
                e.be    = lane_mask(e.size, st_addr_i[2:0]);
                e.valid = 1'b1;
                spec_q.push_back(e);
            end
            // flush also drops a store pushed in the same cycle
            if (flush_i) begin
                foreach (spec_q[i]) begin
                    $display("flush drops store at %h, be %h, size %s",
                             spec_q[i].paddr, spec_q[i].be, spec_q[i].size.name());
                end
                spec_q.delete();
            end
        end
    end

endmodule

// ==== testbench/tb_store_path.sv ====
`timescale 1ns/1ps
`include "sb_consts.svh"

module tb_store_path import lsu_op_pkg::*;;

    localparam int CLK_PERIOD = 100;
    localparam int N_RAND     = 24;
    // random stores, commits and loads plus the directed sequences
    localparam int N_OPS      = 3 * N_RAND + 40;

    logic                clk_i, rst_ni;
    logic                st_valid_i, commit_i, flush_i, ld_valid_i;
    lsu_op_e             st_op_i;
    logic [`SB_PLEN-1:0] st_addr_i, ld_addr_i;
    logic [`SB_XLEN-1:0] st_data_i, ld_rdata_o;
    logic                st_ready_o, st_misaligned_o, commit_ready_o;
    logic                ld_stall_o, ld_rvalid_o, no_st_pending_o, sb_empty_o;
    int                  errors, checks;
    logic [`SB_PLEN-1:0] addrs [$];
    lsu_op_e             op;
    logic [`SB_PLEN-1:0] a;

    store_path_top DUT (.*);

    sb_checker u_checker (.*, .errors_o(errors), .checks_o(checks));

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    // inputs change a little after every rising edge
    task automatic step();
        @(posedge clk_i);
        #10;
    endtask

    task automatic push_store(input lsu_op_e o, input logic [`SB_PLEN-1:0] addr,
                              input logic [`SB_XLEN-1:0] data);
        while (!st_ready_o) step();
        st_valid_i = 1'b1;
        st_op_i    = o;
        st_addr_i  = addr;
        st_data_i  = data;
        step();
        st_valid_i = 1'b0;
    endtask

    task automatic commit_one();
        while (!commit_ready_o) step();
        commit_i = 1'b1;
        step();
        commit_i = 1'b0;
    endtask

    task automatic flush_spec();
        flush_i = 1'b1;
        step();
        flush_i = 1'b0;
    endtask

    // the load is held until it goes through an edge without a stall
    task automatic issue_load(input logic [`SB_PLEN-1:0] addr);
        logic served;
        ld_valid_i = 1'b1;
        ld_addr_i  = addr;
        do begin
            @(negedge clk_i);
            served = !ld_stall_o;
            step();
        end while (!served);
        ld_valid_i = 1'b0;
    endtask

    task automatic wait_drain();
        while (!sb_empty_o) step();
        step();
    endtask

    initial begin : stimulus
        void'($urandom(50399));
        {rst_ni, st_valid_i, commit_i, flush_i, ld_valid_i} = '0;
        st_op_i   = SB;
        st_addr_i = '0;
        st_data_i = '0;
        ld_addr_i = '0;
        repeat (4) @(posedge clk_i);
        #10;
        rst_ni = 1'b1;
        // idle cycles show the reset levels
        repeat (3) step();

        // random aligned stores, each committed and drained, then read back
        for (int i = 0; i < N_RAND; i++) begin
            op = lsu_op_e'($urandom_range(3, 0));
            a  = {$urandom_range(63, 0), 3'b000} | ($urandom_range(7, 0) & ~((1 << op) - 1));
            addrs.push_back(a);
            push_store(op, a, {$urandom, $urandom});
            commit_one();
        end
        wait_drain();
        foreach (addrs[i]) issue_load({addrs[i][`SB_PLEN-1:3], 3'b000});

        // misaligned stores are dropped and leave the words untouched
        push_store(SH, 16'd161, 64'h1111_2222_3333_4444);
        push_store(SW, 16'd170, 64'h5555_6666_7777_8888);
        push_store(SD, 16'd180, 64'h9999_aaaa_bbbb_cccc);
        for (int w = 20; w < 23; w++) issue_load(w * 8);

        // flushed stores never reach memory
        push_store(SD, 16'd800, 64'hdead_beef_0000_0001);
        push_store(SW, 16'd812, 64'hdead_beef_0000_0002);
        flush_spec();
        push_store(SD, 16'd816, 64'h0123_4567_89ab_cdef);
        commit_one();
        wait_drain();
        for (int w = 100; w < 103; w++) issue_load(w * 8);

        // a load on a store pushed in the same cycle stalls until the store drains
        fork
            push_store(SW, 16'd84, 64'h0000_0000_cafe_f00d);
            issue_load(16'd80);
            begin
                repeat (3) step();
                commit_one();
            end
        join
        wait_drain();

        // fill the speculative queue, then fill the commit queue behind loads
        for (int w = 1; w < 4; w++) push_store(SD, w * 8, {$urandom, $urandom});
        step();
        ld_valid_i = 1'b1;
        ld_addr_i  = 16'h0ff8;
        repeat (3) commit_one();
        push_store(SD, 16'd32, {$urandom, $urandom});
        commit_one();
        repeat (3) step();
        ld_valid_i = 1'b0;
        wait_drain();
        for (int w = 1; w < 5; w++) issue_load(w * 8);
        repeat (3) step();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin : watchdog
        #(N_OPS * 20 * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", N_OPS * 20);
        $display("checks: %0d, errors: %0d", checks, errors);
        $display("Some tests failed");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+rtl
rtl/lsu_op_pkg.sv
rtl/mem_port_pkg.sv
rtl/store_req_if.sv
rtl/store_decode.sv
rtl/store_buffer.sv
rtl/data_mem.sv
rtl/store_path_top.sv
testbench/sb_checker.sv
testbench/tb_store_path.sv

// ==== Bender.yml ====
package:
  name: store_path

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/lsu_op_pkg.sv
      - rtl/mem_port_pkg.sv
      - rtl/store_req_if.sv
      - rtl/store_decode.sv
      - rtl/store_buffer.sv
      - rtl/data_mem.sv
      - rtl/store_path_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - testbench/sb_checker.sv
      - testbench/tb_store_path.sv
